//--- Makefile
VERILATOR ?= verilator
TOP       ?= conv_pe_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= *** PASSED ***

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-f $(FILELIST) $(VFLAGS)

run: build
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
hw/pe_cfg_pkg.sv
hw/pe_ctrl_pkg.sv
hw/pe_scratchpad.sv
hw/pe_scratch_loader.sv
hw/pe_mac_sequencer.sv
hw/pe_psum_writer.sv
hw/conv_pe.sv
bench/conv_pe_checker.sv
bench/conv_pe_tb.sv

//--- bench/conv_pe_checker.sv
`timescale 1ns/1ns

module conv_pe_checker
    import pe_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  filt_addr_t filt_len,
    input  if_addr_t   stride_len,
    input  act_t       if_data,
    input  logic       if_read,
    input  wgt_t       filt_data,
    input  logic       filt_read,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  out_idx_t   wb_adr,
    input  psum_t      wb_dat,
    input  logic       wb_ack,
    input  logic       busy,
    input  logic       done,
    output int         value_errors,
    output int         protocol_errors,
    output int         runs_done
);

    act_t     feats[$];
    wgt_t     wgts[$];
    int       val_errs = 0;
    int       prot_errs = 0;
    int       runs = 0;
    int       taps = 1;
    int       stride = 1;
    int       writes = 0;
    logic     started = 1'b0;
    logic     reset_seen = 1'b0;
    logic     active = 1'b0;
    logic     pend = 1'b0;
    out_idx_t pend_adr;
    psum_t    pend_dat;

    assign value_errors    = val_errs;
    assign protocol_errors = prot_errs;
    assign runs_done       = runs;

    // Output idx is the dot product of the filter with the window at idx * stride
    function automatic psum_t ref_psum(input int idx);
        psum_t sum;
        sum = '0;
        for (int k = 0; k < taps; k++) begin
            sum += psum_t'(wgts[k]) * psum_t'(feats[idx * stride + k]);
        end
        return sum;
    endfunction

    function automatic int window_count(input int n, input int f, input int s);
        if (n < f) begin
            return 0;
        end
        return (n - f) / s + 1;
    endfunction

    task automatic expect_low(input string name, input logic val);
        if (val !== 1'b0) begin
            prot_errs++;
            $display("ERROR: %s is not low before the first start", name);
        end
    endtask

    always @(posedge clk) begin
        int    n_exp;
        psum_t exp_dat;
        // Outputs stay quiet through reset until the first start
        if (!started && reset_seen) begin
            expect_low("wb_cyc", wb_cyc);
            expect_low("wb_stb", wb_stb);
            expect_low("if_read", if_read);
            expect_low("filt_read", filt_read);
            expect_low("busy", busy);
            expect_low("done", done);
        end
        if (!arst_n) begin
            reset_seen = 1'b1;
        end
        // Busy spans from the cycle after start up to the done pulse
        if (active && done !== 1'b1) begin
            if (busy !== 1'b1) begin
                prot_errs++;
                $display("ERROR: busy was low during a job before done");
            end
        end else if (started && busy !== 1'b0) begin
            prot_errs++;
            $display("ERROR: busy was high outside a job");
        end
        if (start) begin
            started   = 1'b1;
            active    = 1'b1;
            writes    = 0;
            taps      = (filt_len == '0) ? FILT_DEPTH : int'(filt_len);
            stride    = int'(stride_len);
            feats.delete();
            wgts.delete();
        end

        // Words actually taken at the read strobes
        if (filt_read) begin
            wgts.push_back(filt_data);
        end
        if (if_read) begin
            feats.push_back(if_data);
        end
        n_exp = window_count(feats.size(), taps, stride);

        // Address and data held from strobe to ack
        if (pend) begin
            if (wb_stb !== 1'b1) begin
                prot_errs++;
                $display("ERROR: wb_stb dropped before the slave acknowledged");
            end else if (wb_adr !== pend_adr || wb_dat !== pend_dat) begin
                prot_errs++;
                $display("ERROR: wb_adr or wb_dat changed while waiting for ack");
            end
        end
        pend     = wb_cyc && wb_stb && !wb_ack;
        pend_adr = wb_adr;
        pend_dat = wb_dat;

        if (wb_cyc && wb_stb && wb_ack) begin
            if (wb_we !== 1'b1) begin
                prot_errs++;
                $display("ERROR: bus cycle without wb_we");
            end
            if (writes >= n_exp) begin
                prot_errs++;
                $display("ERROR: write beyond the %0d expected windows", n_exp);
            end else begin
                exp_dat = ref_psum(writes);
                if (wb_adr !== out_idx_t'(writes)) begin
                    val_errs++;
                    $display("CHECK FAILED wb_adr: expected %h, got %h",
                             out_idx_t'(writes), wb_adr);
                end
                if (wb_dat !== exp_dat) begin
                    val_errs++;
                    $display("CHECK FAILED wb_dat at index %0d: expected %h, got %h",
                             writes, exp_dat, wb_dat);
                end
            end
            writes++;
        end

        if (done === 1'b1) begin
            if (!active) begin
                prot_errs++;
                $display("ERROR: done pulsed without a running job");
            end
            if (wb_cyc !== 1'b0) begin
                prot_errs++;
                $display("ERROR: wb_cyc still high with done");
            end
            if (writes != n_exp) begin
                prot_errs++;
                $display("ERROR: %0d writes acked before done, %0d windows expected",
                         writes, n_exp);
            end
            active = 1'b0;
            runs++;
        end
    end

endmodule

//--- bench/conv_pe_tb.sv
`timescale 1ns/1ns

module conv_pe_tb
    import pe_cfg_pkg::*;
;

    localparam int DONE_TIMEOUT = 5000;

    logic       clk = 1'b0;
    logic       arst_n = 1'b0;
    logic       start = 1'b0;
    filt_addr_t filt_len = '0;
    if_addr_t   stride_len = if_addr_t'(1);
    act_t       if_data = '0;
    logic       if_last = 1'b0;
    logic       if_empty = 1'b1;
    logic       if_read;
    wgt_t       filt_data = '0;
    logic       filt_empty = 1'b1;
    logic       filt_read;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    out_idx_t   wb_adr;
    psum_t      wb_dat;
    logic       wb_ack = 1'b0;
    logic       busy;
    logic       done;
    int         value_errors;
    int         protocol_errors;
    int         runs_done;

    logic [31:0] lfsr = 32'h333c448b;
    act_t        feat_mem [IF_DEPTH];
    wgt_t        wgt_mem [FILT_DEPTH];
    int          feat_n = 0;
    int          wgt_n = 0;
    int          feat_ptr = 0;
    int          wgt_ptr = 0;
    int          ack_left = 0;
    logic        ack_armed = 1'b0;
    int          timeouts = 0;
    int          runs_started = 0;

    conv_pe u_conv_pe (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .filt_len   (filt_len),
        .stride_len (stride_len),
        .if_data    (if_data),
        .if_last    (if_last),
        .if_empty   (if_empty),
        .if_read    (if_read),
        .filt_data  (filt_data),
        .filt_empty (filt_empty),
        .filt_read  (filt_read),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack),
        .busy       (busy),
        .done       (done)
    );

    conv_pe_checker u_checker (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (start),
        .filt_len        (filt_len),
        .stride_len      (stride_len),
        .if_data         (if_data),
        .if_read         (if_read),
        .filt_data       (filt_data),
        .filt_read       (filt_read),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat          (wb_dat),
        .wb_ack          (wb_ack),
        .busy            (busy),
        .done            (done),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .runs_done       (runs_done)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // FWFT read ports and Wishbone slave on one LFSR stream
    always @(posedge clk) begin
        logic filt_stall;
        logic feat_stall;
        if (start) begin
            wgt_ptr  = 0;
            feat_ptr = 0;
        end else begin
            if (filt_read) begin
                wgt_ptr = wgt_ptr + 1;
            end
            if (if_read) begin
                feat_ptr = feat_ptr + 1;
            end
        end
        // Roughly one cycle in four shows empty
        filt_stall = (take_bits(2) == 32'd0);
        feat_stall = (take_bits(2) == 32'd0);
        filt_data  <= wgt_mem[wgt_ptr % FILT_DEPTH];
        filt_empty <= (wgt_ptr >= wgt_n) || filt_stall;
        if_data    <= feat_mem[feat_ptr % IF_DEPTH];
        if_last    <= (feat_ptr == feat_n - 1);
        if_empty   <= (feat_ptr >= feat_n) || feat_stall;

        // Ack after 0 to 3 extra cycles
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!ack_armed) begin
                ack_left  = int'(take_bits(2));
                ack_armed = 1'b1;
            end
            if (ack_left == 0) begin
                wb_ack    <= 1'b1;
                ack_armed = 1'b0;
            end else begin
                ack_left = ack_left - 1;
            end
        end
    end

    // One job fills both rows, pulses start and waits for done
    task automatic run_case(input int stride, input int flen, input int nfeat);
        int cycles;
        if (timeouts != 0) begin
            return;
        end
        @(negedge clk);
        for (int i = 0; i < flen; i++) begin
            wgt_mem[i] = wgt_t'(take_bits(8));
        end
        for (int i = 0; i < nfeat; i++) begin
            feat_mem[i] = act_t'(take_bits(8));
        end
        wgt_n  = flen;
        feat_n = nfeat;
        @(posedge clk);
        start      <= 1'b1;
        filt_len   <= filt_addr_t'(flen);
        stride_len <= if_addr_t'(stride);
        runs_started++;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            timeouts++;
            $display("ERROR: no done within %0d cycles (stride %0d, filter %0d, row %0d)",
                     DONE_TIMEOUT, stride, flen, nfeat);
            return;
        end
        repeat (3) @(posedge clk);
    endtask

    initial begin
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge clk);
        run_case(1, 3, 10);
        run_case(2, 1, 15);
        run_case(3, 5, 20);
        run_case(2, 16, 40);
        run_case(3, 1, 17);
        run_case(1, 16, 63);
        // Row shorter than the filter
        run_case(2, 5, 4);
        run_case(1, 3, 10);
        if (timeouts == 0 && runs_done != runs_started) begin
            $display("ERROR: %0d done pulses for %0d jobs", runs_done, runs_started);
        end
        $display("Errors: %0d value, %0d protocol, %0d timeout; jobs %0d of %0d",
                 value_errors, protocol_errors, timeouts, runs_done, runs_started);
        if (value_errors != 0 || protocol_errors != 0 || timeouts != 0 ||
            runs_done != runs_started) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    end

endmodule

//--- hw/conv_pe.sv
`timescale 1ns/1ns

module conv_pe
    import pe_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  filt_addr_t filt_len,
    input  if_addr_t   stride_len,
    input  act_t       if_data,
    input  logic       if_last,
    input  logic       if_empty,
    output logic       if_read,
    input  wgt_t       filt_data,
    input  logic       filt_empty,
    output logic       filt_read,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output out_idx_t   wb_adr,
    output psum_t      wb_dat,
    input  logic       wb_ack,
    output logic       busy,
    output logic       done
);

    logic       if_wen;
    if_addr_t   if_waddr;
    act_t       if_wdata;
    logic       filt_wen;
    filt_addr_t filt_waddr;
    wgt_t       filt_wdata;
    logic       load_done;
    if_addr_t   if_count;
    filt_addr_t filt_size;
    if_addr_t   if_raddr;
    filt_addr_t filt_raddr;
    act_t       if_rdata;
    wgt_t       filt_rdata;
    logic       psum_valid;
    psum_t      psum_data;
    out_idx_t   psum_idx;
    logic       psum_ready;
    logic       write_acked;

    pe_scratch_loader u_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .filt_len   (filt_len),
        .if_data    (if_data),
        .if_last    (if_last),
        .if_empty   (if_empty),
        .if_read    (if_read),
        .filt_data  (filt_data),
        .filt_empty (filt_empty),
        .filt_read  (filt_read),
        .if_wen     (if_wen),
        .if_waddr   (if_waddr),
        .if_wdata   (if_wdata),
        .filt_wen   (filt_wen),
        .filt_waddr (filt_waddr),
        .filt_wdata (filt_wdata),
        .load_done  (load_done),
        .if_count   (if_count),
        .filt_size  (filt_size)
    );

    // Feature row
    pe_scratchpad #(
        .DEPTH (IF_DEPTH),
        .WIDTH ($bits(act_t))
    ) u_if_scratch (
        .clk   (clk),
        .wen   (if_wen),
        .waddr (if_waddr),
        .wdata (if_wdata),
        .raddr (if_raddr),
        .rdata (if_rdata)
    );

    // Filter row
    pe_scratchpad #(
        .DEPTH (FILT_DEPTH),
        .WIDTH ($bits(wgt_t))
    ) u_filt_scratch (
        .clk   (clk),
        .wen   (filt_wen),
        .waddr (filt_waddr),
        .wdata (filt_wdata),
        .raddr (filt_raddr),
        .rdata (filt_rdata)
    );

    pe_mac_sequencer u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .load_done   (load_done),
        .if_count    (if_count),
        .filt_size   (filt_size),
        .stride_len  (stride_len),
        .if_raddr    (if_raddr),
        .filt_raddr  (filt_raddr),
        .if_rdata    (if_rdata),
        .filt_rdata  (filt_rdata),
        .psum_valid  (psum_valid),
        .psum_data   (psum_data),
        .psum_idx    (psum_idx),
        .psum_ready  (psum_ready),
        .write_acked (write_acked),
        .busy        (busy),
        .done        (done)
    );

    pe_psum_writer u_writer (
        .clk         (clk),
        .arst_n      (arst_n),
        .psum_valid  (psum_valid),
        .psum_data   (psum_data),
        .psum_idx    (psum_idx),
        .psum_ready  (psum_ready),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat      (wb_dat),
        .wb_ack      (wb_ack),
        .write_acked (write_acked)
    );

endmodule

//--- hw/pe_cfg_pkg.sv
package pe_cfg_pkg;

    // Element widths
    localparam int ACT_W  = 8;
    localparam int WGT_W  = 8;
    localparam int PROD_W = ACT_W + WGT_W;
    // Room for 16 full-scale products
    localparam int PSUM_W = PROD_W + 8;

    // Scratchpad sizes
    localparam int IF_DEPTH   = 64;
    localparam int FILT_DEPTH = 16;
    localparam int IF_AW      = $clog2(IF_DEPTH);
    localparam int FILT_AW    = $clog2(FILT_DEPTH);

    typedef logic [ACT_W-1:0]   act_t;
    typedef logic [WGT_W-1:0]   wgt_t;
    typedef logic [PROD_W-1:0]  prod_t;
    typedef logic [PSUM_W-1:0]  psum_t;
    typedef logic [IF_AW-1:0]   if_addr_t;
    typedef logic [FILT_AW-1:0] filt_addr_t;

    // Output index doubles as the Wishbone address
    typedef logic [IF_AW-1:0]   out_idx_t;

    // Window arithmetic wide enough for base + stride + filter length
    typedef logic [IF_AW+1:0]   if_span_t;

endpackage

//--- hw/pe_ctrl_pkg.sv
package pe_ctrl_pkg;

    // Scratchpad loader
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_LOAD_FILT,
        LD_LOAD_IF,
        LD_READY
    } loader_state_t;

    // MAC sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DRAIN,
        SEQ_FINISH
    } seq_state_t;

    // Wishbone writer
    typedef enum logic {
        WB_IDLE,
        WB_BUS
    } wb_state_t;

endpackage

//--- hw/pe_mac_sequencer.sv
`timescale 1ns/1ns

module pe_mac_sequencer
    import pe_cfg_pkg::*;
    import pe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic       load_done,
    input  if_addr_t   if_count,
    input  filt_addr_t filt_size,
    input  if_addr_t   stride_len,
    output if_addr_t   if_raddr,
    output filt_addr_t filt_raddr,
    input  act_t       if_rdata,
    input  wgt_t       filt_rdata,
    output logic       psum_valid,
    output psum_t      psum_data,
    output out_idx_t   psum_idx,
    input  logic       psum_ready,
    input  logic       write_acked,
    output logic       busy,
    output logic       done
);

    seq_state_t state;
    if_addr_t   base;
    filt_addr_t tap;
    logic       drain_cnt;
    logic       rd_v;
    logic       prod_v;
    prod_t      prod_q;
    psum_t      acc;
    out_idx_t   issued_cnt;
    out_idx_t   acked_cnt;
    if_span_t   taps;
    if_span_t   next_base;
    logic       first_fits;
    logic       next_fits;
    logic       last_tap;
    logic       handoff;
    logic       stall;

    // Zero length means a full filter row
    assign taps = (filt_size == '0) ? if_span_t'(FILT_DEPTH) : if_span_t'(filt_size);

    assign next_base  = if_span_t'(base) + if_span_t'(stride_len);
    assign first_fits = taps <= if_span_t'(if_count);
    assign next_fits  = (next_base + taps) <= if_span_t'(if_count);
    assign last_tap   = (if_span_t'(tap) == taps - 1'b1);

    assign handoff = psum_valid && psum_ready;
    // Only ever true at tap 0 of the next window, or while finishing
    assign stall   = psum_valid && !psum_ready;

    assign if_raddr   = base + if_addr_t'(tap);
    assign filt_raddr = tap;

    assign psum_data = acc;
    assign psum_idx  = issued_cnt;

    // Product register then accumulator
    always_ff @(posedge clk) begin
        if (rd_v) begin
            prod_q <= if_rdata * filt_rdata;
        end
        if (load_done || handoff) begin
            acc <= '0;
        end else if (prod_v) begin
            acc <= acc + psum_t'(prod_q);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= SEQ_IDLE;
            base       <= '0;
            tap        <= '0;
            drain_cnt  <= 1'b0;
            rd_v       <= 1'b0;
            prod_v     <= 1'b0;
            psum_valid <= 1'b0;
            issued_cnt <= '0;
            acked_cnt  <= '0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            done   <= 1'b0;
            rd_v   <= (state == SEQ_RUN) && !stall;
            prod_v <= rd_v;

            if (handoff) begin
                psum_valid <= 1'b0;
                issued_cnt <= issued_cnt + 1'b1;
            end
            if (write_acked) begin
                acked_cnt <= acked_cnt + 1'b1;
            end
            if (start) begin
                busy       <= 1'b1;
                issued_cnt <= '0;
                acked_cnt  <= '0;
            end

            case (state)
                SEQ_IDLE: begin
                    if (load_done) begin
                        base  <= '0;
                        tap   <= '0;
                        state <= first_fits ? SEQ_RUN : SEQ_FINISH;
                    end
                end
                SEQ_RUN: begin
                    if (!stall) begin
                        tap <= tap + 1'b1;
                        if (last_tap) begin
                            drain_cnt <= 1'b0;
                            state     <= SEQ_DRAIN;
                        end
                    end
                end
                SEQ_DRAIN: begin
                    // Two cycles for the read and product stages to empty
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        psum_valid <= 1'b1;
                        tap        <= '0;
                        if (next_fits) begin
                            base  <= if_addr_t'(next_base);
                            state <= SEQ_RUN;
                        end else begin
                            state <= SEQ_FINISH;
                        end
                    end
                end
                SEQ_FINISH: begin
                    if (!psum_valid && (acked_cnt == issued_cnt)) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

//--- hw/pe_psum_writer.sv
`timescale 1ns/1ns

module pe_psum_writer
    import pe_cfg_pkg::*;
    import pe_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     psum_valid,
    input  psum_t    psum_data,
    input  out_idx_t psum_idx,
    output logic     psum_ready,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output out_idx_t wb_adr,
    output psum_t    wb_dat,
    input  logic     wb_ack,
    output logic     write_acked
);

    wb_state_t state;

    // One sum held at a time
    assign psum_ready = (state == WB_IDLE);

    // Classic single write with strobes held until ack
    assign wb_cyc = (state == WB_BUS);
    assign wb_stb = wb_cyc;
    assign wb_we  = wb_cyc;

    assign write_acked = wb_cyc && wb_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (psum_valid) begin
                        state <= WB_BUS;
                    end
                end
                WB_BUS: begin
                    if (wb_ack) begin
                        state <= WB_IDLE;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Address and data stay stable for the whole bus cycle
    always_ff @(posedge clk) begin
        if (psum_valid && psum_ready) begin
            wb_adr <= psum_idx;
            wb_dat <= psum_data;
        end
    end

endmodule

//--- hw/pe_scratch_loader.sv
`timescale 1ns/1ns

module pe_scratch_loader
    import pe_cfg_pkg::*;
    import pe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  filt_addr_t filt_len,
    input  act_t       if_data,
    input  logic       if_last,
    input  logic       if_empty,
    output logic       if_read,
    input  wgt_t       filt_data,
    input  logic       filt_empty,
    output logic       filt_read,
    output logic       if_wen,
    output if_addr_t   if_waddr,
    output act_t       if_wdata,
    output logic       filt_wen,
    output filt_addr_t filt_waddr,
    output wgt_t       filt_wdata,
    output logic       load_done,
    output if_addr_t   if_count,
    output filt_addr_t filt_size
);

    loader_state_t state;
    filt_addr_t    filt_ptr;
    logic          if_full;

    // Feature count saturates at the last scratchpad entry
    assign if_full = (if_count == if_addr_t'(IF_DEPTH - 1));

    // FWFT ports take the word shown whenever the FIFO is not empty
    assign filt_read = (state == LD_LOAD_FILT) && !filt_empty;
    assign if_read   = (state == LD_LOAD_IF) && !if_empty;

    assign filt_wen   = filt_read;
    assign filt_waddr = filt_ptr;
    assign filt_wdata = filt_data;

    // Words past a full scratchpad are still drained up to the end marker
    assign if_wen   = if_read && !if_full;
    assign if_waddr = if_count;
    assign if_wdata = if_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= LD_IDLE;
            filt_ptr  <= '0;
            filt_size <= '0;
            if_count  <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (state)
                LD_IDLE, LD_READY: begin
                    if (start) begin
                        filt_size <= filt_len;
                        filt_ptr  <= '0;
                        if_count  <= '0;
                        state     <= LD_LOAD_FILT;
                    end
                end
                LD_LOAD_FILT: begin
                    if (filt_read) begin
                        filt_ptr <= filt_ptr + 1'b1;
                        // A length of zero wraps and loads all 16 taps
                        if (filt_ptr == filt_addr_t'(filt_size - 1'b1)) begin
                            state <= LD_LOAD_IF;
                        end
                    end
                end
                LD_LOAD_IF: begin
                    if (if_read) begin
                        if (!if_full) begin
                            if_count <= if_count + 1'b1;
                        end
                        if (if_last) begin
                            state     <= LD_READY;
                            load_done <= 1'b1;
                        end
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

endmodule

//--- hw/pe_scratchpad.sv
`timescale 1ns/1ns

module pe_scratchpad #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Single write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data lags the address by one cycle
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule
